//--- source/rv_issue_pkg.sv
package rv_issue_pkg;

    // ****************************************
    // widths and defaults
    // ****************************************

    localparam int xlen                = 32;  // instruction and immediate word
    localparam int reg_idx_w           = 5;
    localparam int default_fpu_latency = 4;   // cycles the FPU stays busy per op

    // ****************************************
    // opcode field, instruction bits 6:2
    // ****************************************

    typedef enum logic [4:0] {
        opc_load      = 5'b00000,
        opc_fp_load   = 5'b00001,
        opc_arith_imm = 5'b00100,
        opc_auipc     = 5'b00101,
        opc_store     = 5'b01000,
        opc_fp_store  = 5'b01001,
        opc_arith_reg = 5'b01100,
        opc_lui       = 5'b01101,
        opc_fp_madd   = 5'b10000,
        opc_fp_op     = 5'b10100,
        opc_branch    = 5'b11000,
        opc_jalr      = 5'b11001,
        opc_jal       = 5'b11011
    } opcode_e;

    // upper four bits of funct7 select the single precision op
    typedef enum logic [3:0] {
        f4_add     = 4'b0000,
        f4_fsgnj_s = 4'b0010,
        f4_cvt_s_w = 4'b1101,
        f4_mv_x_w  = 4'b1110,
        f4_mv_w_x  = 4'b1111
    } fp_funct4_e;

    localparam logic [6:0] fp_mv_x_w_funct7 = 7'b1110000;  // fmv.x.w writes an integer rd

    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_j,
        imm_u
    } imm_kind_e;

endpackage

//--- source/id_ex_if.sv
`timescale 1ns/1ns

interface id_ex_if;

    logic                          valid;  // one cycle per issued instruction
    logic [rv_issue_pkg::xlen-1:0] inst;
    logic [rv_issue_pkg::xlen-1:0] imm;
    logic                          is_fp;  // op goes to the FPU

    modport issue (
        output valid,
        output inst,
        output imm,
        output is_fp
    );

    modport capture (
        input valid,
        input inst,
        input imm,
        input is_fp
    );

endinterface

//--- source/inst_buffer.sv
`timescale 1ns/1ns

module inst_buffer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          inst_valid,
    input  logic [rv_issue_pkg::xlen-1:0] inst,
    input  logic                          stall,
    output logic                          id_valid,
    output logic [rv_issue_pkg::xlen-1:0] id_inst
);

    // ****************************************
    // decode stage register
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (inst_valid) begin
            id_valid <= 1'b1;  // fetch only strobes when stall is low
        end else if (!stall) begin
            id_valid <= 1'b0;  // held word has issued
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            id_inst <= inst;
        end
    end

endmodule

//--- source/id_control.sv
`timescale 1ns/1ns

module id_control (
    input  logic                          id_valid,
    input  logic [rv_issue_pkg::xlen-1:0] id_inst,
    input  logic [rv_issue_pkg::xlen-1:0] ex_inst,
    input  logic [rv_issue_pkg::xlen-1:0] ex_fp_inst,
    input  logic                          fpu_busy,
    output rv_issue_pkg::imm_kind_e       imm_kind,
    output logic                          stall,
    input  logic [rv_issue_pkg::xlen-1:0] imm,
    id_ex_if.issue                        ex
);

    rv_issue_pkg::opcode_e              opcode;
    rv_issue_pkg::opcode_e              ex_opcode;
    rv_issue_pkg::opcode_e              ex_fp_opcode;
    rv_issue_pkg::fp_funct4_e           funct4;
    logic                               legal;
    logic                               ex_legal;
    logic                               ex_fp_legal;
    logic [rv_issue_pkg::reg_idx_w-1:0] rs1;
    logic [rv_issue_pkg::reg_idx_w-1:0] rs2;
    logic [rv_issue_pkg::reg_idx_w-1:0] rs3;
    logic [rv_issue_pkg::reg_idx_w-1:0] ex_rd;
    logic [rv_issue_pkg::reg_idx_w-1:0] ex_fp_fd;
    logic                               op_fp_store;
    logic                               op_fp;
    logic                               op_fp_madd;
    logic                               has_rs1;
    logic                               has_rs2;
    logic                               has_fs1;
    logic                               has_fs2;
    logic                               has_fs3;
    logic                               ex_has_rd;
    logic                               ex_has_load_fd;
    logic                               ex_fp_has_fd;
    logic                               rs_hazard;
    logic                               fs_load_hazard;
    logic                               fs_fpu_hazard;
    logic                               fpu_inst;

    assign legal       = (id_inst[1:0] == 2'b11);  // zero word decodes as no opcode
    assign ex_legal    = (ex_inst[1:0] == 2'b11);
    assign ex_fp_legal = (ex_fp_inst[1:0] == 2'b11);

    assign opcode       = rv_issue_pkg::opcode_e'(id_inst[6:2]);
    assign ex_opcode    = rv_issue_pkg::opcode_e'(ex_inst[6:2]);
    assign ex_fp_opcode = rv_issue_pkg::opcode_e'(ex_fp_inst[6:2]);
    assign funct4       = rv_issue_pkg::fp_funct4_e'(id_inst[31:28]);

    assign rs1      = id_inst[19:15];  // integer and FP sources share the fields
    assign rs2      = id_inst[24:20];
    assign rs3      = id_inst[31:27];
    assign ex_rd    = ex_inst[11:7];
    assign ex_fp_fd = ex_fp_inst[11:7];

    assign op_fp_store = legal && (opcode == rv_issue_pkg::opc_fp_store);
    assign op_fp       = legal && (opcode == rv_issue_pkg::opc_fp_op);
    assign op_fp_madd  = legal && (opcode == rv_issue_pkg::opc_fp_madd);

    // ****************************************
    // sources read by the decode instruction
    // ****************************************

    assign has_rs1 = legal && (rs1 != '0) && ((opcode inside {rv_issue_pkg::opc_arith_imm,
        rv_issue_pkg::opc_arith_reg, rv_issue_pkg::opc_load, rv_issue_pkg::opc_store,
        rv_issue_pkg::opc_branch, rv_issue_pkg::opc_jalr, rv_issue_pkg::opc_fp_load,
        rv_issue_pkg::opc_fp_store}) || (op_fp && (funct4 inside {rv_issue_pkg::f4_mv_w_x,
        rv_issue_pkg::f4_cvt_s_w})));
    assign has_rs2 = legal && (rs2 != '0) && (opcode inside {rv_issue_pkg::opc_arith_reg,
        rv_issue_pkg::opc_store, rv_issue_pkg::opc_branch});

    assign has_fs1 = op_fp_madd || (op_fp && (funct4 inside {rv_issue_pkg::f4_mv_x_w,
        rv_issue_pkg::f4_fsgnj_s, rv_issue_pkg::f4_add}));
    assign has_fs2 = op_fp_store || op_fp_madd
        || (op_fp && (funct4 inside {rv_issue_pkg::f4_fsgnj_s, rv_issue_pkg::f4_add}));
    assign has_fs3 = op_fp_madd;  // fused ops read a third FP source

    // ****************************************
    // destinations ahead of decode
    // ****************************************

    assign ex_has_rd = ex_legal && ((ex_opcode inside {rv_issue_pkg::opc_arith_imm,
        rv_issue_pkg::opc_arith_reg, rv_issue_pkg::opc_load, rv_issue_pkg::opc_jal,
        rv_issue_pkg::opc_jalr, rv_issue_pkg::opc_lui, rv_issue_pkg::opc_auipc})
        || ((ex_opcode == rv_issue_pkg::opc_fp_op)
        && (ex_inst[31:25] == rv_issue_pkg::fp_mv_x_w_funct7)));
    assign ex_has_load_fd = ex_legal && (ex_opcode == rv_issue_pkg::opc_fp_load);
    assign ex_fp_has_fd = ex_fp_legal && ((ex_fp_opcode == rv_issue_pkg::opc_fp_madd)
        || ((ex_fp_opcode == rv_issue_pkg::opc_fp_op)
        && (ex_fp_inst[31:25] != rv_issue_pkg::fp_mv_x_w_funct7)));

    assign rs_hazard = ex_has_rd && ((has_rs1 && (rs1 == ex_rd)) || (has_rs2 && (rs2 == ex_rd)));
    assign fs_load_hazard = ex_has_load_fd && ((has_fs1 && (rs1 == ex_rd))
        || (has_fs2 && (rs2 == ex_rd)) || (has_fs3 && (rs3 == ex_rd)));
    assign fs_fpu_hazard = ex_fp_has_fd && ((has_fs1 && (rs1 == ex_fp_fd))
        || (has_fs2 && (rs2 == ex_fp_fd)) || (has_fs3 && (rs3 == ex_fp_fd)));

    assign fpu_inst = op_fp || op_fp_madd;
    assign stall = id_valid
        && (rs_hazard || fs_load_hazard || fs_fpu_hazard || (fpu_inst && fpu_busy));

    assign ex.valid = id_valid && !stall;
    assign ex.inst  = id_inst;
    assign ex.imm   = imm;
    assign ex.is_fp = fpu_inst;

    always_comb begin
        imm_kind = rv_issue_pkg::imm_none;
        if (legal) begin
            case (opcode)
                rv_issue_pkg::opc_arith_imm, rv_issue_pkg::opc_load,
                rv_issue_pkg::opc_jalr, rv_issue_pkg::opc_fp_load: imm_kind = rv_issue_pkg::imm_i;
                rv_issue_pkg::opc_store, rv_issue_pkg::opc_fp_store: imm_kind = rv_issue_pkg::imm_s;
                rv_issue_pkg::opc_branch: imm_kind = rv_issue_pkg::imm_b;
                rv_issue_pkg::opc_jal: imm_kind = rv_issue_pkg::imm_j;
                rv_issue_pkg::opc_lui, rv_issue_pkg::opc_auipc: imm_kind = rv_issue_pkg::imm_u;
                default: imm_kind = rv_issue_pkg::imm_none;
            endcase
        end
    end

endmodule

//--- source/imm_gen.sv
`timescale 1ns/1ns

module imm_gen (
    input  logic [rv_issue_pkg::xlen-1:0] inst,
    input  rv_issue_pkg::imm_kind_e       imm_kind,
    output logic [rv_issue_pkg::xlen-1:0] imm
);

    localparam int xlen = rv_issue_pkg::xlen;

    logic sign;

    assign sign = inst[31];  // every signed format keeps its sign in bit 31

    // ****************************************
    // immediate assembly
    // ****************************************

    always_comb begin
        case (imm_kind)
            rv_issue_pkg::imm_i: begin
                imm = {{(xlen-12){sign}}, inst[31:20]};
            end
            rv_issue_pkg::imm_s: begin
                imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
            end
            rv_issue_pkg::imm_b: begin
                imm = {{(xlen-13){sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_issue_pkg::imm_j: begin
                imm = {{(xlen-21){sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            rv_issue_pkg::imm_u: begin
                imm = {inst[31:12], 12'b0};  // upper immediate is never extended
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- source/ex_tracker.sv
`timescale 1ns/1ns

module ex_tracker #(
    parameter int FPU_LATENCY = rv_issue_pkg::default_fpu_latency
) (
    input  logic                          clk,
    input  logic                          rst_n,
    id_ex_if.capture                      ex,
    output logic [rv_issue_pkg::xlen-1:0] ex_inst,
    output logic [rv_issue_pkg::xlen-1:0] ex_fp_inst,
    output logic                          fpu_busy,
    output logic                          issue_valid,
    output logic [rv_issue_pkg::xlen-1:0] issue_inst,
    output logic [rv_issue_pkg::xlen-1:0] issue_imm,
    output logic                          fpu_start,
    output logic [rv_issue_pkg::xlen-1:0] fpu_inst
);

    localparam int CNT_W = $clog2(FPU_LATENCY + 1);

    logic [CNT_W-1:0] busy_cnt;
    logic             fpu_issue;

    assign fpu_issue = ex.valid && ex.is_fp;

    // ****************************************
    // execute stage register
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
            ex_inst     <= '0;
        end else begin
            issue_valid <= ex.valid;
            ex_inst     <= ex.valid ? ex.inst : '0;  // zero word is the bubble
        end
    end

    always_ff @(posedge clk) begin
        if (ex.valid) begin
            issue_imm <= ex.imm;
        end
    end

    assign issue_inst = ex_inst;

    // ****************************************
    // in-flight FP op and busy count
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fpu_start  <= 1'b0;
            busy_cnt   <= '0;
            ex_fp_inst <= '0;
        end else begin
            fpu_start <= fpu_issue;
            if (fpu_issue) begin
                busy_cnt   <= CNT_W'(FPU_LATENCY);
                ex_fp_inst <= ex.inst;
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
                if (busy_cnt == CNT_W'(1)) begin
                    ex_fp_inst <= '0;  // leaves together with fpu_busy
                end
            end
        end
    end

    assign fpu_busy = (busy_cnt != '0);
    assign fpu_inst = ex_fp_inst;

endmodule

//--- source/issue_stage.sv
`timescale 1ns/1ns

module issue_stage #(
    parameter int FPU_LATENCY = rv_issue_pkg::default_fpu_latency
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          inst_valid,
    input  logic [rv_issue_pkg::xlen-1:0] inst,
    output logic                          stall,
    output logic                          issue_valid,
    output logic [rv_issue_pkg::xlen-1:0] issue_inst,
    output logic [rv_issue_pkg::xlen-1:0] issue_imm,
    output logic                          fpu_start,
    output logic [rv_issue_pkg::xlen-1:0] fpu_inst
);

    logic                          id_valid;
    logic [rv_issue_pkg::xlen-1:0] id_inst;
    rv_issue_pkg::imm_kind_e       imm_kind;
    logic [rv_issue_pkg::xlen-1:0] imm;
    logic [rv_issue_pkg::xlen-1:0] ex_inst;
    logic [rv_issue_pkg::xlen-1:0] ex_fp_inst;
    logic                          fpu_busy;

    id_ex_if ex_bus ();  // decode to execute

    inst_buffer inst_buffer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_valid(inst_valid),
        .inst      (inst),
        .stall     (stall),
        .id_valid  (id_valid),
        .id_inst   (id_inst)
    );

    id_control id_control_inst (
        .id_valid  (id_valid),
        .id_inst   (id_inst),
        .ex_inst   (ex_inst),
        .ex_fp_inst(ex_fp_inst),
        .fpu_busy  (fpu_busy),
        .imm_kind  (imm_kind),
        .stall     (stall),
        .imm       (imm),
        .ex        (ex_bus.issue)
    );

    imm_gen imm_gen_inst (
        .inst    (id_inst),
        .imm_kind(imm_kind),
        .imm     (imm)
    );

    ex_tracker #(
        .FPU_LATENCY(FPU_LATENCY)
    ) ex_tracker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex         (ex_bus.capture),
        .ex_inst    (ex_inst),
        .ex_fp_inst (ex_fp_inst),
        .fpu_busy   (fpu_busy),
        .issue_valid(issue_valid),
        .issue_inst (issue_inst),
        .issue_imm  (issue_imm),
        .fpu_start  (fpu_start),
        .fpu_inst   (fpu_inst)
    );

endmodule

//--- tb/tb_issue_stage.sv
`timescale 1ns/1ns

module tb_issue_stage;

    localparam int period         = 20;
    localparam int lat            = rv_issue_pkg::default_fpu_latency;
    localparam int stream_timeout = 40;  // cycles allowed for one stream to issue
    localparam int stream_count   = 9;
    localparam int wd_cycles      = stream_count * (stream_timeout + lat + 12) + 20;

    logic        clk        = 1'b0;
    logic        rst_n      = 1'b0;
    logic        inst_valid = 1'b0;
    logic [31:0] inst       = '0;
    logic        stall;
    logic        issue_valid;
    logic [31:0] issue_inst;
    logic [31:0] issue_imm;
    logic        fpu_start;
    logic [31:0] fpu_inst;

    logic [31:0] lfsr_state  = 32'h7f9b139a;
    int          cyc         = 0;
    int          stall_cnt   = 0;
    int          checks      = 0;
    int          errors      = 0;
    int          test_errors = 0;
    int          tests       = 0;

    // what was sent, and what came out
    logic [31:0]             sent_inst[$];
    logic [31:0]             sent_imm[$];
    rv_issue_pkg::imm_kind_e sent_kind[$];
    int                      sent_cyc[$];
    int                      sent_stall[$];
    bit                      sent_fp[$];
    logic [31:0]             iss_inst[$];
    logic [31:0]             iss_imm[$];
    int                      iss_cyc[$];
    rv_issue_pkg::imm_kind_e dec_kind[$];
    logic [31:0]             fpu_inst_q[$];
    int                      fpu_cyc_q[$];

    issue_stage issue_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .stall      (stall),
        .issue_valid(issue_valid),
        .issue_inst (issue_inst),
        .issue_imm  (issue_imm),
        .fpu_start  (fpu_start),
        .fpu_inst   (fpu_inst)
    );

    always #(period / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ****************************************
    // monitor, sampled mid-cycle
    // ****************************************

    always @(negedge clk) begin
        if (issue_valid) begin
            iss_inst.push_back(issue_inst);
            iss_imm.push_back(issue_imm);
            iss_cyc.push_back(cyc);
        end
        if (fpu_start) begin
            fpu_inst_q.push_back(fpu_inst);
            fpu_cyc_q.push_back(cyc);
        end
        if (stall) begin
            stall_cnt++;
        end
        if (issue_stage_inst.id_valid && !stall) begin
            dec_kind.push_back(issue_stage_inst.imm_kind);  // kind of the word leaving decode
        end
    end

    initial begin
        #(wd_cycles * period);
        $display("watchdog expired after %0d cycles", wd_cycles);
        $display("TB FAILED");
        $finish;
    end

    // ****************************************
    // stimulus and encoding model
    // ****************************************

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return val;
    endfunction

    function automatic logic [4:0] dst_reg();
        logic [31:0] b;
        b = lfsr_bits(4);
        return {1'b1, b[3:0]};  // writers use x16..x31, readers x0..x15
    endfunction

    function automatic logic [4:0] src_reg();
        logic [31:0] b;
        b = lfsr_bits(4);
        return {1'b0, b[3:0]};
    endfunction

    function automatic logic [31:0] enc_i(input rv_issue_pkg::opcode_e opc, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_s(input rv_issue_pkg::opcode_e opc, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_b(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
                rv_issue_pkg::opc_branch, 2'b11};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_issue_pkg::opc_jal, 2'b11};
    endfunction

    function automatic logic [31:0] enc_u(input rv_issue_pkg::opcode_e opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_r(input rv_issue_pkg::opcode_e opc, input logic [6:0] f7,
                                          input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] fadd(input logic [4:0] fd, input logic [4:0] fs1,
                                         input logic [4:0] fs2);
        return enc_r(rv_issue_pkg::opc_fp_op, {rv_issue_pkg::f4_add, 3'b000}, fs2, fs1, fd);
    endfunction

    // the word becomes visible in the cycle after the drive edge
    task automatic send_inst(input logic [31:0] word, input logic [31:0] exp_imm,
                             input rv_issue_pkg::imm_kind_e kind, input int stalls,
                             input bit is_fp);
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        sent_inst.push_back(word);
        sent_imm.push_back(exp_imm);
        sent_kind.push_back(kind);
        sent_cyc.push_back(cyc + 1);
        sent_stall.push_back(stalls);
        sent_fp.push_back(is_fp);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= word;
    endtask

    task automatic release_bus();
        @(posedge clk);
        inst_valid <= 1'b0;
    endtask

    // ****************************************
    // checks
    // ****************************************

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            count_error();
        end
    endtask

    task automatic compare_kind(input string name, input rv_issue_pkg::imm_kind_e got,
                                input rv_issue_pkg::imm_kind_e exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            count_error();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            count_error();
        end
    endtask

    task automatic clear_stream();
        sent_inst.delete();
        sent_imm.delete();
        sent_kind.delete();
        sent_cyc.delete();
        sent_stall.delete();
        sent_fp.delete();
        iss_inst.delete();
        iss_imm.delete();
        iss_cyc.delete();
        dec_kind.delete();
        fpu_inst_q.delete();
        fpu_cyc_q.delete();
        stall_cnt = 0;
    endtask

    // waits for every sent word, lets the FPU drain, then compares the whole stream
    task automatic check_stream();
        int waited;
        int stall_exp;
        int f;
        waited    = 0;
        stall_exp = 0;
        f         = 0;
        while ((iss_inst.size() < sent_inst.size()) && (waited < stream_timeout)) begin
            @(posedge clk);
            waited++;
        end
        repeat (lat + 3) @(posedge clk);
        if ((iss_inst.size() != sent_inst.size()) || (dec_kind.size() != sent_inst.size())) begin
            $display("%0d instructions were sent but %0d issued", sent_inst.size(),
                     iss_inst.size());
            count_error();
        end else begin
            foreach (sent_inst[i]) begin
                compare_word("issue_inst", iss_inst[i], sent_inst[i]);
                compare_word("issue_imm", iss_imm[i], sent_imm[i]);
                compare_kind("imm_kind", dec_kind[i], sent_kind[i]);
                compare_word("issue cycle", iss_cyc[i], sent_cyc[i] + 2 + sent_stall[i]);
                stall_exp += sent_stall[i];
                if (sent_fp[i] && (f < fpu_inst_q.size())) begin
                    compare_word("fpu_inst", fpu_inst_q[f], sent_inst[i]);
                    compare_word("fpu_start cycle", fpu_cyc_q[f],
                                 sent_cyc[i] + 2 + sent_stall[i]);
                end
                f += sent_fp[i];
            end
            compare_word("fpu_start pulses", fpu_inst_q.size(), f);
            compare_word("stall cycles", stall_cnt, stall_exp);
        end
        clear_stream();
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ****************************************
    // directed tests
    // ****************************************

    task automatic test_reset_state();
        @(negedge clk);
        compare_bit("stall", stall, 1'b0);
        compare_bit("issue_valid", issue_valid, 1'b0);
        compare_bit("fpu_start", fpu_start, 1'b0);
        finish_test("reset state");
    endtask

    task automatic test_int_issue();
        logic [11:0] imm_i;
        logic [11:0] imm_s;
        logic [12:0] imm_b;
        logic [20:0] imm_j;
        logic [19:0] imm_u;
        imm_i = 12'(lfsr_bits(12));
        imm_s = 12'(lfsr_bits(12));
        imm_b = 13'(lfsr_bits(12) << 1);
        imm_j = 21'(lfsr_bits(20) << 1);
        imm_u = 20'(lfsr_bits(20));
        send_inst(enc_i(rv_issue_pkg::opc_arith_imm, dst_reg(), src_reg(), imm_i),
                  {{20{imm_i[11]}}, imm_i}, rv_issue_pkg::imm_i, 0, 1'b0);
        send_inst(enc_s(rv_issue_pkg::opc_store, src_reg(), src_reg(), imm_s),
                  {{20{imm_s[11]}}, imm_s}, rv_issue_pkg::imm_s, 0, 1'b0);
        send_inst(enc_b(src_reg(), src_reg(), imm_b), {{19{imm_b[12]}}, imm_b},
                  rv_issue_pkg::imm_b, 0, 1'b0);
        send_inst(enc_j(dst_reg(), imm_j), {{11{imm_j[20]}}, imm_j}, rv_issue_pkg::imm_j, 0, 1'b0);
        send_inst(enc_u(rv_issue_pkg::opc_lui, dst_reg(), imm_u), {imm_u, 12'h000},
                  rv_issue_pkg::imm_u, 0, 1'b0);
        send_inst(enc_r(rv_issue_pkg::opc_arith_reg, 7'h00, src_reg(), src_reg(), dst_reg()),
                  '0, rv_issue_pkg::imm_none, 0, 1'b0);
        release_bus();
        check_stream();
        finish_test("integer issue");
    endtask

    // writer followed at once by an add that reads rs1 = seen
    task automatic run_pair(input logic [31:0] w, input logic [31:0] w_imm,
                            input rv_issue_pkg::imm_kind_e w_kind, input logic [4:0] seen,
                            input int stalls);
        send_inst(w, w_imm, w_kind, 0, 1'b0);
        send_inst(enc_r(rv_issue_pkg::opc_arith_reg, 7'h00, src_reg(), seen, dst_reg()),
                  '0, rv_issue_pkg::imm_none, stalls, 1'b0);
        release_bus();
        check_stream();
    endtask

    task automatic test_int_hazard();
        logic [4:0]  a;
        logic [11:0] imm12;
        logic [12:0] imm13;
        a = dst_reg();
        imm12 = 12'(lfsr_bits(12));
        run_pair(enc_i(rv_issue_pkg::opc_arith_imm, a, src_reg(), imm12),
                 {{20{imm12[11]}}, imm12}, rv_issue_pkg::imm_i, a, 1);
        run_pair(enc_i(rv_issue_pkg::opc_arith_imm, 5'd0, src_reg(), imm12),
                 {{20{imm12[11]}}, imm12}, rv_issue_pkg::imm_i, 5'd0, 0);
        a = dst_reg();
        imm12 = {7'(lfsr_bits(7)), a};  // store offset low bits sit in the rd field
        run_pair(enc_s(rv_issue_pkg::opc_store, src_reg(), src_reg(), imm12),
                 {{20{imm12[11]}}, imm12}, rv_issue_pkg::imm_s, a, 0);
        a = dst_reg();
        imm13 = {1'(lfsr_bits(1)), a[0], 6'(lfsr_bits(6)), a[4:1], 1'b0};
        run_pair(enc_b(src_reg(), src_reg(), imm13), {{19{imm13[12]}}, imm13},
                 rv_issue_pkg::imm_b, a, 0);
        finish_test("integer hazard");
    endtask

    task automatic test_fpu_busy();
        send_inst(fadd(dst_reg(), src_reg(), src_reg()), '0, rv_issue_pkg::imm_none, 0, 1'b1);
        send_inst(fadd(dst_reg(), src_reg(), src_reg()), '0, rv_issue_pkg::imm_none, lat, 1'b1);
        release_bus();
        check_stream();
        finish_test("fpu busy");
    endtask

    task automatic test_fp_store_hazard();
        logic [4:0]  fd;
        logic [11:0] imm12;
        fd = dst_reg();
        imm12 = 12'(lfsr_bits(12));
        send_inst(fadd(fd, src_reg(), src_reg()), '0, rv_issue_pkg::imm_none, 0, 1'b1);
        send_inst(enc_s(rv_issue_pkg::opc_fp_store, src_reg(), fd, imm12),
                  {{20{imm12[11]}}, imm12}, rv_issue_pkg::imm_s, lat, 1'b0);
        release_bus();
        check_stream();
        fd = dst_reg();  // fmv.x.w names an integer rd, so no FP hazard
        send_inst(enc_r(rv_issue_pkg::opc_fp_op, rv_issue_pkg::fp_mv_x_w_funct7, 5'd0,
                        src_reg(), fd), '0, rv_issue_pkg::imm_none, 0, 1'b1);
        send_inst(enc_s(rv_issue_pkg::opc_fp_store, src_reg(), fd, imm12),
                  {{20{imm12[11]}}, imm12}, rv_issue_pkg::imm_s, 0, 1'b0);
        release_bus();
        check_stream();
        finish_test("fp store hazard");
    endtask

    task automatic test_fp_load_hazard();
        logic [4:0]  fd;
        logic [11:0] imm12;
        fd = dst_reg();
        imm12 = 12'(lfsr_bits(12));
        send_inst(enc_i(rv_issue_pkg::opc_fp_load, fd, src_reg(), imm12),
                  {{20{imm12[11]}}, imm12}, rv_issue_pkg::imm_i, 0, 1'b0);
        send_inst(fadd(dst_reg(), fd, src_reg()), '0, rv_issue_pkg::imm_none, 1, 1'b1);
        release_bus();
        check_stream();
        finish_test("fp load hazard");
    endtask

    initial begin
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_int_issue();
        test_int_hazard();
        test_fpu_busy();
        test_fp_store_hazard();
        test_fp_load_hazard();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
source/rv_issue_pkg.sv
source/id_ex_if.sv
source/inst_buffer.sv
source/id_control.sv
source/imm_gen.sv
source/ex_tracker.sv
source/issue_stage.sv
tb/tb_issue_stage.sv
